// ==== dv/spectrum_sva.sv ====
`timescale 1ns/1ps

module spectrum_sva #(
    parameter int H_DISP   = 64,
    parameter int H_SYNC   = 8,
    parameter int V_DISP   = 48,
    parameter int N_POINTS = 16
) (
    input logic                        pixel_clk,
    input logic                        sys_rst_n,
    input logic                        bin_we,
    input logic [$clog2(N_POINTS)-1:0] bin_addr,
    input spectrum_pkg::mag_t          bin_mag,
    input logic                        bin_commit,
    input logic                        hdmi_hs,
    input logic                        hdmi_vs,
    input logic                        hdmi_de,
    input video_pkg::rgb_t             hdmi_rgb
);

    import video_pkg::*;
    import spectrum_pkg::*;

    localparam int BAR_W = H_DISP / N_POINTS;

    mag_t                        bank_a [N_POINTS];   // mirrored banks
    mag_t                        bank_b [N_POINTS];
    bank_sel_t                   disp_bank;
    logic                        pending;
    logic                        we_d;                // inputs, one cycle late
    logic                        commit_d;
    logic [$clog2(N_POINTS)-1:0] addr_d;
    mag_t                        mag_d;
    logic                        de_q;
    logic                        vs_q;
    logic                        new_frame;           // no pixel of this frame yet
    logic                        first_pix;           // matches frame_start inside
    int                          col;
    int                          row;
    int                          hs_len;
    logic                        err_seen = 1'b0;     // sticky, watched by the testbench
    mag_t                        cur_mag;
    rgb_t                        exp_rgb;
    logic                        interior;

    //****************************************
    // bank model and raster recovery
    //****************************************
    assign first_pix = hdmi_de && new_frame;

    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < N_POINTS; i++) begin
                bank_a[i] <= '0;
                bank_b[i] <= '0;
            end
            disp_bank <= BANK_A;
            pending   <= 1'b0;
            we_d      <= 1'b0;
            commit_d  <= 1'b0;
            addr_d    <= '0;
            mag_d     <= '0;
            de_q      <= 1'b0;
            vs_q      <= 1'b0;
            new_frame <= 1'b1;
            col       <= 0;
            row       <= 0;
            hs_len    <= 0;
        end else begin
            we_d     <= bin_we;   // output lags the store by one cycle
            commit_d <= bin_commit;
            addr_d   <= bin_addr;
            mag_d    <= bin_mag;
            if (we_d && disp_bank == BANK_A) bank_b[addr_d] <= mag_d;
            if (we_d && disp_bank == BANK_B) bank_a[addr_d] <= mag_d;
            if (first_pix && pending) disp_bank <= (disp_bank == BANK_A) ? BANK_B : BANK_A;
            pending <= commit_d || (pending && !first_pix);
            de_q    <= hdmi_de;
            vs_q    <= hdmi_vs;
            col     <= hdmi_de ? col + 1 : 0;
            hs_len  <= hdmi_hs ? hs_len + 1 : 0;
            if (hdmi_vs && !vs_q) begin
                row       <= 0;   // frame boundary
                new_frame <= 1'b1;
            end else begin
                if (de_q && !hdmi_de) row <= row + 1;
                if (hdmi_de) new_frame <= 1'b0;
            end
        end
    end

    // expected colour of the bar interior
    always_comb begin
        cur_mag  = (disp_bank == BANK_A) ? bank_a[(col / BAR_W) % N_POINTS]
                                         : bank_b[(col / BAR_W) % N_POINTS];
        interior = (col % BAR_W) >= 2;   // first two columns may show the previous bin
        exp_rgb  = (cur_mag != '0 && row + int'(cur_mag) >= V_DISP) ? COLOR_RED : COLOR_WHITE;
    end

    //****************************************
    // assertions
    //****************************************
    a_reset: assert property (@(posedge pixel_clk)
        !sys_rst_n |-> !hdmi_de && !hdmi_hs && !hdmi_vs && hdmi_rgb == COLOR_BLACK)
        else begin
            err_seen = 1'b1;
            $error("CHECK FAILED hdmi_rgb in reset: expected %h actual %h",
                   COLOR_BLACK, $sampled(hdmi_rgb));
        end

    a_blank: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        !hdmi_de |-> hdmi_rgb == COLOR_BLACK)
        else begin
            err_seen = 1'b1;
            $error("CHECK FAILED hdmi_rgb blanking: expected %h actual %h",
                   COLOR_BLACK, $sampled(hdmi_rgb));
        end

    a_bar: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        hdmi_de && interior |-> hdmi_rgb == exp_rgb)
        else begin
            err_seen = 1'b1;
            $error("CHECK FAILED hdmi_rgb at col %h row %h: expected %h actual %h",
                   $sampled(col), $sampled(row), $sampled(exp_rgb), $sampled(hdmi_rgb));
        end

    a_line: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        de_q && !hdmi_de |-> col == H_DISP)
        else begin
            err_seen = 1'b1;
            $error("CHECK FAILED hdmi_de per line: expected %h actual %h", H_DISP, $sampled(col));
        end

    a_hsync: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        hs_len != 0 && !hdmi_hs |-> hs_len == H_SYNC)
        else begin
            err_seen = 1'b1;
            $error("CHECK FAILED hdmi_hs width: expected %h actual %h", H_SYNC, $sampled(hs_len));
        end

    a_frame: assert property (@(posedge pixel_clk) disable iff (!sys_rst_n)
        hdmi_vs && !vs_q |-> row == V_DISP)
        else begin
            err_seen = 1'b1;
            $error("CHECK FAILED hdmi_de lines per frame: expected %h actual %h",
                   V_DISP, $sampled(row));
        end

endmodule

bind spectrum_top spectrum_sva #(
    .H_DISP(H_DISP), .H_SYNC(H_SYNC), .V_DISP(V_DISP), .N_POINTS(N_POINTS)
) u_sva (.*);

// ==== dv/tb_spectrum.sv ====
`timescale 1ns/1ps

module tb_spectrum;

    import video_pkg::*;
    import spectrum_pkg::*;

    localparam int H_DISP   = 64;
    localparam int V_DISP   = 48;
    localparam int N_POINTS = 16;
    localparam int FRAME_TO = 10000;   // cycles, frame total is 4320

    logic        pixel_clk;
    logic        sys_rst_n;
    logic        bin_we;
    logic [3:0]  bin_addr;
    mag_t        bin_mag;
    logic        bin_commit;
    logic        hdmi_hs;
    logic        hdmi_vs;
    logic        hdmi_de;
    rgb_t        hdmi_rgb;
    logic [31:0] lcg_state;

    spectrum_top #(
        .H_DISP(H_DISP), .H_FRONT(4), .H_SYNC(8), .H_BACK(4),
        .V_DISP(V_DISP), .V_FRONT(2), .V_SYNC(2), .V_BACK(2),
        .N_POINTS(N_POINTS)
    ) u_dut (.*);

    initial begin
        pixel_clk = 1'b0;
        forever #20 pixel_clk = ~pixel_clk;   // 25 MHz
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rising edge of the output vsync, sampled mid cycle
    task automatic wait_frame();
        int   cnt;
        logic prev;
        cnt = 0;
        do begin
            prev = hdmi_vs;
            @(negedge pixel_clk);
            cnt++;
            if (cnt > FRAME_TO) begin
                $display("timeout while waiting for a rising edge of hdmi_vs");
                $display("TEST FAILED");
                $fatal(1);
            end
        end while (!(hdmi_vs && !prev));
    endtask

    // all bins into the back bank, optionally with an empty and an overfull bin
    task automatic write_bins(input bit extremes);
        mag_t m;
        for (int i = 0; i < N_POINTS; i++) begin
            lcg_state = lcg_next(lcg_state);
            m = mag_t'((lcg_state >> 16) % (V_DISP + 8));
            if (extremes && i == 0) m = '0;
            if (extremes && i == N_POINTS - 1) m = mag_t'(V_DISP + 7);
            @(posedge pixel_clk);
            bin_we   <= 1'b1;
            bin_addr <= 4'(i);
            bin_mag  <= m;
        end
        @(posedge pixel_clk);
        bin_we <= 1'b0;
    endtask

    task automatic commit_bins();
        @(posedge pixel_clk);
        bin_commit <= 1'b1;
        @(posedge pixel_clk);
        bin_commit <= 1'b0;
    endtask

    always @(posedge u_dut.u_sva.err_seen) begin
        $display("TEST FAILED");
        $fatal(1, "assertion error in the bound checker");
    end

    //****************************************
    // stimulus
    //****************************************
    initial begin
        sys_rst_n  = 1'b1;
        bin_we     = 1'b0;
        bin_addr   = '0;
        bin_mag    = '0;
        bin_commit = 1'b0;
        lcg_state  = 32'h8421;
        #1 sys_rst_n = 1'b0;   // real falling edge for the async reset
        repeat (10) @(posedge pixel_clk);
        sys_rst_n <= 1'b1;
        wait_frame();          // all white
        write_bins(1'b1);
        commit_bins();
        wait_frame();
        wait_frame();
        write_bins(1'b0);      // hidden bank only
        wait_frame();
        commit_bins();
        wait_frame();
        @(negedge pixel_clk);
        if (u_dut.u_sva.err_seen) begin
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== files.f ====
source/video_pkg.sv
source/spectrum_pkg.sv
source/video_if.sv
source/spectrum_if.sv
source/video_timing.sv
source/spectrum_store.sv
source/spectrum_display.sv
source/spectrum_top.sv
dv/spectrum_sva.sv
dv/tb_spectrum.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_spectrum -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== source/spectrum_display.sv ====
`timescale 1ns/1ps

module spectrum_display #(
    parameter int H_DISP   = video_pkg::DEF_H_DISP,
    parameter int V_DISP   = video_pkg::DEF_V_DISP,
    parameter int N_POINTS = spectrum_pkg::DEF_N_POINTS
) (
    input  logic            pixel_clk,
    input  logic            sys_rst_n,
    video_if.snk            vid,
    spectrum_if.req         fetch,
    output logic            hs,
    output logic            vs,
    output logic            de,
    output video_pkg::rgb_t rgb
);

    import video_pkg::*;

    localparam int BAR_W = H_DISP / N_POINTS;   // columns per bin

    coord_t bar_last;   // last column of the current bar
    logic   bar_hit;    // pixel is inside the red part of the column

    //****************************************
    // bar window and colour decision
    //****************************************
    assign bar_last = coord_t'((int'(fetch.point_idx) + 1) * BAR_W - 1);

    // ypos + mag >= V_DISP, done wide so tall bins do not wrap
    assign bar_hit = (fetch.magnitude != '0) &&
                     ((int'(vid.ypos) + int'(fetch.magnitude)) >= V_DISP);

    // bin fetch strobes
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            fetch.data_req  <= 1'b0;
            fetch.line_done <= 1'b0;
        end else begin
            fetch.data_req  <= vid.de && (vid.xpos == bar_last);     // end of bar
            fetch.line_done <= (vid.xpos == coord_t'(H_DISP - 1));   // end of line
        end
    end

    // pixel out, syncs delayed with the colour
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hs  <= 1'b0;
            vs  <= 1'b0;
            de  <= 1'b0;
            rgb <= COLOR_BLACK;
        end else begin
            hs <= vid.hs;
            vs <= vid.vs;
            de <= vid.de;
            if (!vid.de) begin
                rgb <= COLOR_BLACK;   // blanking
            end else if (bar_hit) begin
                rgb <= COLOR_RED;
            end else begin
                rgb <= COLOR_WHITE;   // above the bar or empty bin
            end
        end
    end

endmodule

// ==== source/spectrum_if.sv ====
`timescale 1ns/1ps

interface spectrum_if #(
    parameter int N_POINTS = spectrum_pkg::DEF_N_POINTS
);

    import spectrum_pkg::*;

    logic                        data_req;    // step to next bin
    logic                        line_done;   // rewind to bin 0
    logic [$clog2(N_POINTS)-1:0] point_idx;   // bin being painted
    mag_t                        magnitude;   // display bank at point_idx

    // display side, pulls bins in order
    modport req (output data_req, output line_done,
                 input point_idx, input magnitude);

    // store side
    modport rsp (input data_req, input line_done,
                 output point_idx, output magnitude);

endinterface

// ==== source/spectrum_pkg.sv ====
package spectrum_pkg;

    // magnitude counts in display rows
    localparam int MAG_W = 11;
    typedef logic [MAG_W-1:0] mag_t;

    // bins per line, power of two
    // index width is $clog2 of the bin count
    localparam int DEF_N_POINTS = 256;

    //****************************************
    // double buffer bank select
    //****************************************
    // names the bank currently on screen
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_sel_t;

endpackage

// ==== source/spectrum_store.sv ====
`timescale 1ns/1ps

module spectrum_store #(
    parameter int N_POINTS = spectrum_pkg::DEF_N_POINTS
) (
    input  logic                        pixel_clk,
    input  logic                        sys_rst_n,
    input  logic                        bin_we,       // write into back bank
    input  logic [$clog2(N_POINTS)-1:0] bin_addr,
    input  spectrum_pkg::mag_t          bin_mag,
    input  logic                        bin_commit,   // request swap
    video_if.snk                        vid,
    spectrum_if.rsp                     fetch
);

    import spectrum_pkg::*;

    localparam int IDX_W = $clog2(N_POINTS);

    mag_t             bank_a [N_POINTS];
    mag_t             bank_b [N_POINTS];
    bank_sel_t        disp_bank;   // bank on screen
    logic             pending;     // commit seen, swap at next frame
    logic [IDX_W-1:0] idx;         // per line bin pointer

    //****************************************
    // bin writes, always to the hidden bank
    //****************************************
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < N_POINTS; i++) begin
                bank_a[i] <= '0;
                bank_b[i] <= '0;
            end
        end else if (bin_we) begin
            if (disp_bank == BANK_A) begin
                bank_b[bin_addr] <= bin_mag;
            end else begin
                bank_a[bin_addr] <= bin_mag;
            end
        end
    end

    // swap only on a frame boundary, no tearing
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            disp_bank <= BANK_A;
            pending   <= 1'b0;
        end else begin
            if (vid.frame_start && pending) begin
                disp_bank <= (disp_bank == BANK_A) ? BANK_B : BANK_A;
            end
            // a commit in the swap cycle waits for the following frame
            pending <= bin_commit || (pending && !vid.frame_start);
        end
    end

    // bin pointer, line_done wins over the last data_req of a line
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            idx <= '0;
        end else if (fetch.line_done) begin
            idx <= '0;
        end else if (fetch.data_req) begin
            idx <= idx + 1'b1;   // wraps at N_POINTS
        end
    end

    assign fetch.point_idx = idx;
    assign fetch.magnitude = (disp_bank == BANK_A) ? bank_a[idx] : bank_b[idx];   // no latency

endmodule

// ==== source/spectrum_top.sv ====
`timescale 1ns/1ps

module spectrum_top #(
    parameter int H_DISP   = video_pkg::DEF_H_DISP,
    parameter int H_FRONT  = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
    parameter int H_BACK   = video_pkg::DEF_H_BACK,
    parameter int V_DISP   = video_pkg::DEF_V_DISP,
    parameter int V_FRONT  = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
    parameter int V_BACK   = video_pkg::DEF_V_BACK,
    parameter int N_POINTS = spectrum_pkg::DEF_N_POINTS
) (
    input  logic                        pixel_clk,
    input  logic                        sys_rst_n,
    input  logic                        bin_we,       // bin write strobe
    input  logic [$clog2(N_POINTS)-1:0] bin_addr,
    input  spectrum_pkg::mag_t          bin_mag,
    input  logic                        bin_commit,   // swap at next frame
    output logic                        hdmi_hs,
    output logic                        hdmi_vs,
    output logic                        hdmi_de,
    output video_pkg::rgb_t             hdmi_rgb
);

    video_if                            vid_bus ();
    spectrum_if #(.N_POINTS(N_POINTS))  fetch_bus ();

    // raster
    video_timing #(
        .H_DISP (H_DISP),  .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_DISP (V_DISP),  .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .pixel_clk (pixel_clk),
        .sys_rst_n (sys_rst_n),
        .vid       (vid_bus)
    );

    // double buffered bins
    spectrum_store #(
        .N_POINTS (N_POINTS)
    ) u_store (
        .pixel_clk  (pixel_clk),
        .sys_rst_n  (sys_rst_n),
        .bin_we     (bin_we),
        .bin_addr   (bin_addr),
        .bin_mag    (bin_mag),
        .bin_commit (bin_commit),
        .vid        (vid_bus),
        .fetch      (fetch_bus)
    );

    // bar painter, one cycle behind the raster
    spectrum_display #(
        .H_DISP   (H_DISP),
        .V_DISP   (V_DISP),
        .N_POINTS (N_POINTS)
    ) u_display (
        .pixel_clk (pixel_clk),
        .sys_rst_n (sys_rst_n),
        .vid       (vid_bus),
        .fetch     (fetch_bus),
        .hs        (hdmi_hs),
        .vs        (hdmi_vs),
        .de        (hdmi_de),
        .rgb       (hdmi_rgb)
    );

endmodule

// ==== source/video_if.sv ====
`timescale 1ns/1ps

interface video_if;

    import video_pkg::*;

    coord_t xpos;          // counts over full line total
    coord_t ypos;          // counts over full frame total
    logic   de;            // active area
    logic   hs;            // active high
    logic   vs;            // active high
    logic   frame_start;   // single pulse at (0,0)

    // timing generator side
    modport src (output xpos, output ypos, output de, output hs, output vs,
                 output frame_start);

    // consumers
    modport snk (input xpos, input ypos, input de, input hs, input vs,
                 input frame_start);

endinterface

// ==== source/video_pkg.sv ====
package video_pkg;

    // raster types
    typedef logic [10:0] coord_t;   // pixel position, up to 2047
    typedef logic [23:0] rgb_t;     // rgb888, red in the top byte

    //****************************************
    // colour constants
    //****************************************
    localparam rgb_t COLOR_WHITE = 24'hFF_FF_FF;   // background of the chart
    localparam rgb_t COLOR_RED   = 24'hFF_00_00;   // bar colour
    localparam rgb_t COLOR_BLACK = 24'h00_00_00;   // blanking

    //****************************************
    // default timing, 1280x720 at 74.25 MHz
    //****************************************
    localparam logic [10:0] DEF_H_DISP  = 11'd1280;
    localparam logic [10:0] DEF_H_FRONT = 11'd110;
    localparam logic [10:0] DEF_H_SYNC  = 11'd40;
    localparam logic [10:0] DEF_H_BACK  = 11'd220;   // line total 1650

    localparam logic [10:0] DEF_V_DISP  = 11'd720;
    localparam logic [10:0] DEF_V_FRONT = 11'd5;
    localparam logic [10:0] DEF_V_SYNC  = 11'd5;
    localparam logic [10:0] DEF_V_BACK  = 11'd20;    // frame total 750

endpackage

// ==== source/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
    parameter int H_DISP  = video_pkg::DEF_H_DISP,
    parameter int H_FRONT = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC  = video_pkg::DEF_H_SYNC,
    parameter int H_BACK  = video_pkg::DEF_H_BACK,
    parameter int V_DISP  = video_pkg::DEF_V_DISP,
    parameter int V_FRONT = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC  = video_pkg::DEF_V_SYNC,
    parameter int V_BACK  = video_pkg::DEF_V_BACK
) (
    input  logic pixel_clk,
    input  logic sys_rst_n,
    video_if.src vid
);

    import video_pkg::*;

    localparam int H_TOTAL   = H_DISP + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_DISP + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START  = H_DISP + H_FRONT;   // sync follows front porch
    localparam int VS_START  = V_DISP + V_FRONT;

    coord_t h_cnt;
    coord_t v_cnt;
    coord_t h_next;
    coord_t v_next;
    logic   h_wrap;    // last pixel of the line

    //****************************************
    // next position
    //****************************************
    assign h_wrap = (h_cnt == coord_t'(H_TOTAL - 1));
    assign h_next = h_wrap ? '0 : h_cnt + 1'b1;
    assign v_next = !h_wrap                        ? v_cnt :
                    (v_cnt == coord_t'(V_TOTAL - 1)) ? '0    :
                                                       v_cnt + 1'b1;

    // flags are decoded from the next position, so they line up with it
    always_ff @(posedge pixel_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            // park on the last pixel of the frame, first edge lands on (0,0)
            h_cnt           <= coord_t'(H_TOTAL - 1);
            v_cnt           <= coord_t'(V_TOTAL - 1);
            vid.de          <= 1'b0;
            vid.hs          <= 1'b0;
            vid.vs          <= 1'b0;
            vid.frame_start <= 1'b0;
        end else begin
            h_cnt           <= h_next;
            v_cnt           <= v_next;
            vid.de          <= (h_next < coord_t'(H_DISP)) && (v_next < coord_t'(V_DISP));
            vid.hs          <= (h_next >= coord_t'(HS_START)) &&
                               (h_next <  coord_t'(HS_START + H_SYNC));
            vid.vs          <= (v_next >= coord_t'(VS_START)) &&
                               (v_next <  coord_t'(VS_START + V_SYNC));
            vid.frame_start <= (h_next == '0) && (v_next == '0);   // top left
        end
    end

    assign vid.xpos = h_cnt;
    assign vid.ypos = v_cnt;

endmodule
